//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       ?= tb_decode
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_decode with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    logic                               hit;
    logic                               reg_write_en;
    logic                               reg1_read_en;
    logic                               reg2_read_en;
    logic [la_decode_pkg::ALUOP_W-1:0]  aluop;
    logic [la_decode_pkg::ALUSEL_W-1:0] alusel;
    logic [31:0]                        imm;
    logic                               is_privilege;
    logic [4:0]                         invtlb_op;

    modport decoder (
        output hit, reg_write_en, reg1_read_en, reg2_read_en,
        output aluop, alusel, imm, is_privilege, invtlb_op
    );

    modport stage (
        input hit, reg_write_en, reg1_read_en, reg2_read_en,
        input aluop, alusel, imm, is_privilege, invtlb_op
    );
endinterface

`default_nettype wire

//--- hw/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                fetch_valid,
    input  wire                                stall,
    input  wire                                flush,
    input  wire  [31:0]                        pc,
    input  wire  [31:0]                        inst,
    output wire                                id_valid,
    output wire  [31:0]                        pc_out,
    output wire  [31:0]                        inst_out,
    output wire                                reg_write_en,
    output wire  [la_decode_pkg::ALUOP_W-1:0]  aluop,
    output wire  [la_decode_pkg::ALUSEL_W-1:0] alusel,
    output wire  [31:0]                        imm,
    output wire                                reg1_read_en,
    output wire                                reg2_read_en,
    output wire  [4:0]                         reg1_read_addr,
    output wire  [4:0]                         reg2_read_addr,
    output wire  [4:0]                         reg_write_addr,
    output wire                                is_privilege,
    output wire  [4:0]                         invtlb_op,
    output wire  [1:0]                         is_exception,
    output wire  [la_decode_pkg::ECODE_W-1:0]  pc_exception_cause,
    output wire  [la_decode_pkg::ECODE_W-1:0]  decoder_exception_cause
);
    decode_if d3r ();
    decode_if d2ri12 ();
    decode_if d1ri20 ();

    id_3r u_id_3r (
        .inst (inst),
        .dec  (d3r)
    );

    id_2ri12 u_id_2ri12 (
        .inst (inst),
        .dec  (d2ri12)
    );

    id_1ri20 u_id_1ri20 (
        .inst (inst),
        .dec  (d1ri20)
    );

    // every stage port matches a top port or bundle by name
    id_stage u_id_stage (.*);
endmodule

`default_nettype wire

//--- hw/id_1ri20.sv
`timescale 1ns/1ps
`default_nettype none

module id_1ri20 (
    input wire la_decode_pkg::inst_word_t inst,
    decode_if.decoder                     dec
);
    always_comb begin
        dec.hit          = 1'b1;
        dec.reg_write_en = 1'b1;
        dec.reg1_read_en = 1'b0;
        dec.reg2_read_en = 1'b0;
        dec.imm          = {inst.fmt_1ri20.si20, 12'b0};
        dec.is_privilege = 1'b0;
        dec.invtlb_op    = 5'b0;

        case (inst.fmt_1ri20.opcode)
            la_decode_pkg::LU12IW_OPCODE: begin
                dec.aluop  = la_decode_pkg::ALU_LU12IW;
                dec.alusel = la_decode_pkg::ALU_SEL_LUI;
            end
            la_decode_pkg::PCADDU12I_OPCODE: begin  // execute adds pc
                dec.aluop  = la_decode_pkg::ALU_PCADDU12I;
                dec.alusel = la_decode_pkg::ALU_SEL_ARITHMETIC;
            end
            default: begin
                dec.hit          = 1'b0;
                dec.reg_write_en = 1'b0;
                dec.aluop        = la_decode_pkg::ALU_NOP;
                dec.alusel       = la_decode_pkg::ALU_SEL_NOP;
                dec.imm          = 32'b0;
            end
        endcase
    end
endmodule

`default_nettype wire

//--- hw/id_2ri12.sv
`timescale 1ns/1ps
`default_nettype none

module id_2ri12 (
    input wire la_decode_pkg::inst_word_t inst,
    decode_if.decoder                     dec
);
    logic [11:0] si12;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign si12     = inst.fmt_2ri12.si12;
    assign imm_sext = {{20{si12[11]}}, si12};
    assign imm_zext = {20'b0, si12};  // logical ops

    always_comb begin
        dec.hit          = 1'b1;
        dec.reg_write_en = 1'b1;
        dec.reg1_read_en = 1'b1;
        dec.reg2_read_en = 1'b0;
        dec.alusel       = la_decode_pkg::ALU_SEL_ARITHMETIC;
        dec.imm          = imm_sext;
        dec.is_privilege = 1'b0;
        dec.invtlb_op    = 5'b0;

        case (inst.fmt_2ri12.opcode)
            la_decode_pkg::ADDIW_OPCODE: dec.aluop = la_decode_pkg::ALU_ADDIW;
            la_decode_pkg::SLTI_OPCODE:  dec.aluop = la_decode_pkg::ALU_SLTI;
            la_decode_pkg::SLTUI_OPCODE: dec.aluop = la_decode_pkg::ALU_SLTUI;
            la_decode_pkg::ANDI_OPCODE: begin
                dec.aluop = la_decode_pkg::ALU_ANDI;
                dec.imm   = imm_zext;
            end
            la_decode_pkg::ORI_OPCODE: begin
                dec.aluop = la_decode_pkg::ALU_ORI;
                dec.imm   = imm_zext;
            end
            la_decode_pkg::XORI_OPCODE: begin
                dec.aluop = la_decode_pkg::ALU_XORI;
                dec.imm   = imm_zext;
            end
            default: begin
                dec.hit          = 1'b0;
                dec.reg_write_en = 1'b0;
                dec.reg1_read_en = 1'b0;
                dec.aluop        = la_decode_pkg::ALU_NOP;
                dec.alusel       = la_decode_pkg::ALU_SEL_NOP;
                dec.imm          = 32'b0;
            end
        endcase
    end
endmodule

`default_nettype wire

//--- hw/id_3r.sv
`timescale 1ns/1ps
`default_nettype none

module id_3r (
    input wire la_decode_pkg::inst_word_t inst,
    decode_if.decoder                     dec
);
    logic [16:0] opcode;
    logic [4:0]  ui5;

    assign opcode = inst.fmt_3r.opcode;
    assign ui5    = inst.fmt_3r.rk;  // shift amount lives in rk

    always_comb begin
        dec.hit          = 1'b1;
        dec.reg_write_en = 1'b1;
        dec.reg1_read_en = 1'b1;
        dec.reg2_read_en = 1'b1;
        dec.alusel       = la_decode_pkg::ALU_SEL_ARITHMETIC;
        dec.imm          = 32'b0;
        dec.is_privilege = 1'b0;
        dec.invtlb_op    = 5'b0;

        case (opcode)
            la_decode_pkg::ADDW_OPCODE:    dec.aluop = la_decode_pkg::ALU_ADDW;
            la_decode_pkg::SUBW_OPCODE:    dec.aluop = la_decode_pkg::ALU_SUBW;
            la_decode_pkg::SLT_OPCODE:     dec.aluop = la_decode_pkg::ALU_SLT;
            la_decode_pkg::SLTU_OPCODE:    dec.aluop = la_decode_pkg::ALU_SLTU;
            la_decode_pkg::NOR_OPCODE:     dec.aluop = la_decode_pkg::ALU_NOR;
            la_decode_pkg::AND_OPCODE:     dec.aluop = la_decode_pkg::ALU_AND;
            la_decode_pkg::OR_OPCODE:      dec.aluop = la_decode_pkg::ALU_OR;
            la_decode_pkg::XOR_OPCODE:     dec.aluop = la_decode_pkg::ALU_XOR;
            la_decode_pkg::SLLW_OPCODE:    dec.aluop = la_decode_pkg::ALU_SLLW;
            la_decode_pkg::SRLW_OPCODE:    dec.aluop = la_decode_pkg::ALU_SRLW;
            la_decode_pkg::SRAW_OPCODE:    dec.aluop = la_decode_pkg::ALU_SRAW;
            la_decode_pkg::MULW_OPCODE:    dec.aluop = la_decode_pkg::ALU_MULW;
            la_decode_pkg::MULHW_OPCODE:   dec.aluop = la_decode_pkg::ALU_MULHW;
            la_decode_pkg::MULHWU_OPCODE:  dec.aluop = la_decode_pkg::ALU_MULHWU;
            la_decode_pkg::DIVW_OPCODE:    dec.aluop = la_decode_pkg::ALU_DIVW;
            la_decode_pkg::MODW_OPCODE:    dec.aluop = la_decode_pkg::ALU_MODW;
            la_decode_pkg::DIVWU_OPCODE:   dec.aluop = la_decode_pkg::ALU_DIVWU;
            la_decode_pkg::MODWU_OPCODE:   dec.aluop = la_decode_pkg::ALU_MODWU;
            la_decode_pkg::BREAK_OPCODE:   dec.aluop = la_decode_pkg::ALU_BREAK;
            la_decode_pkg::SYSCALL_OPCODE: dec.aluop = la_decode_pkg::ALU_SYSCALL;
            la_decode_pkg::SLLIW_OPCODE:   dec.aluop = la_decode_pkg::ALU_SLLIW;
            la_decode_pkg::SRLIW_OPCODE:   dec.aluop = la_decode_pkg::ALU_SRLIW;
            la_decode_pkg::SRAIW_OPCODE:   dec.aluop = la_decode_pkg::ALU_SRAIW;
            la_decode_pkg::IDLE_OPCODE:    dec.aluop = la_decode_pkg::ALU_IDLE;
            la_decode_pkg::INVTLB_OPCODE:  dec.aluop = la_decode_pkg::ALU_INVTLB;
            la_decode_pkg::DBAR_OPCODE:    dec.aluop = la_decode_pkg::ALU_DBAR;
            la_decode_pkg::IBAR_OPCODE:    dec.aluop = la_decode_pkg::ALU_IBAR;
            default:                       dec.aluop = la_decode_pkg::ALU_NOP;
        endcase

        // per-group attributes
        case (opcode)
            la_decode_pkg::MULW_OPCODE, la_decode_pkg::MULHW_OPCODE,
            la_decode_pkg::MULHWU_OPCODE, la_decode_pkg::DIVW_OPCODE,
            la_decode_pkg::MODW_OPCODE, la_decode_pkg::DIVWU_OPCODE,
            la_decode_pkg::MODWU_OPCODE:
                dec.alusel = la_decode_pkg::ALU_SEL_MUL;
            la_decode_pkg::SLLIW_OPCODE, la_decode_pkg::SRLIW_OPCODE,
            la_decode_pkg::SRAIW_OPCODE: begin
                dec.reg2_read_en = 1'b0;
                dec.imm          = {27'b0, ui5};
            end
            la_decode_pkg::INVTLB_OPCODE: begin  // reads rj/rk, op in rd
                dec.reg_write_en = 1'b0;
                dec.alusel       = la_decode_pkg::ALU_SEL_NOP;
                dec.is_privilege = 1'b1;
                dec.invtlb_op    = inst.fmt_3r.rd;
            end
            la_decode_pkg::IDLE_OPCODE, la_decode_pkg::BREAK_OPCODE,
            la_decode_pkg::SYSCALL_OPCODE, la_decode_pkg::DBAR_OPCODE,
            la_decode_pkg::IBAR_OPCODE: begin
                dec.reg_write_en = 1'b0;
                dec.reg1_read_en = 1'b0;
                dec.reg2_read_en = 1'b0;
                dec.alusel       = la_decode_pkg::ALU_SEL_NOP;
                dec.is_privilege = (opcode == la_decode_pkg::IDLE_OPCODE);
            end
            default: ;
        endcase

        if (dec.aluop == la_decode_pkg::ALU_NOP) begin  // not a 3R word
            dec.hit          = 1'b0;
            dec.reg_write_en = 1'b0;
            dec.reg1_read_en = 1'b0;
            dec.reg2_read_en = 1'b0;
            dec.alusel       = la_decode_pkg::ALU_SEL_NOP;
        end
    end
endmodule

`default_nettype wire

//--- hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  fetch_valid,
    input  wire                                  stall,
    input  wire                                  flush,
    input  wire  [31:0]                          pc,
    input  wire  [31:0]                          inst,
    decode_if.stage                              d3r,
    decode_if.stage                              d2ri12,
    decode_if.stage                              d1ri20,
    output logic                                 id_valid,
    output logic [31:0]                          pc_out,
    output logic [31:0]                          inst_out,
    output logic                                 reg_write_en,
    output logic [la_decode_pkg::ALUOP_W-1:0]    aluop,
    output logic [la_decode_pkg::ALUSEL_W-1:0]   alusel,
    output logic [31:0]                          imm,
    output logic                                 reg1_read_en,
    output logic                                 reg2_read_en,
    output logic [4:0]                           reg1_read_addr,
    output logic [4:0]                           reg2_read_addr,
    output logic [4:0]                           reg_write_addr,
    output logic                                 is_privilege,
    output logic [4:0]                           invtlb_op,
    output logic [1:0]                           is_exception,
    output logic [la_decode_pkg::ECODE_W-1:0]    pc_exception_cause,
    output logic [la_decode_pkg::ECODE_W-1:0]    decoder_exception_cause
);
    logic dec_miss;
    logic pc_misaligned;
    logic capture;

    assign dec_miss      = ~(d3r.hit | d2ri12.hit | d1ri20.hit);
    assign pc_misaligned = |pc[1:0];
    assign capture       = fetch_valid & ~stall & ~flush;

    // a missing decoder drives zeros, so or-ing the bundles selects the hit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid                <= 1'b0;
            reg_write_en            <= 1'b0;
            reg1_read_en            <= 1'b0;
            reg2_read_en            <= 1'b0;
            is_privilege            <= 1'b0;
            aluop                   <= la_decode_pkg::ALU_NOP;
            alusel                  <= la_decode_pkg::ALU_SEL_NOP;
            is_exception            <= 2'b0;
            pc_exception_cause      <= la_decode_pkg::ECODE_NONE;
            decoder_exception_cause <= la_decode_pkg::ECODE_NONE;
        end else if (flush) begin  // beats stall
            id_valid                <= 1'b0;
            is_exception            <= 2'b0;
            pc_exception_cause      <= la_decode_pkg::ECODE_NONE;
            decoder_exception_cause <= la_decode_pkg::ECODE_NONE;
        end else if (!stall) begin
            id_valid <= fetch_valid;
            if (fetch_valid) begin
                reg_write_en <= ~dec_miss &
                                (d3r.reg_write_en | d2ri12.reg_write_en | d1ri20.reg_write_en);
                reg1_read_en <= ~dec_miss &
                                (d3r.reg1_read_en | d2ri12.reg1_read_en | d1ri20.reg1_read_en);
                reg2_read_en <= ~dec_miss &
                                (d3r.reg2_read_en | d2ri12.reg2_read_en | d1ri20.reg2_read_en);
                is_privilege <= d3r.is_privilege | d2ri12.is_privilege | d1ri20.is_privilege;
                aluop        <= d3r.aluop | d2ri12.aluop | d1ri20.aluop;
                alusel       <= d3r.alusel | d2ri12.alusel | d1ri20.alusel;
                is_exception <= {dec_miss, pc_misaligned};
                pc_exception_cause <= pc_misaligned ? la_decode_pkg::ECODE_ADEF
                                                    : la_decode_pkg::ECODE_NONE;
                decoder_exception_cause <= dec_miss ? la_decode_pkg::ECODE_INE
                                                    : la_decode_pkg::ECODE_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pc_out         <= pc;
            inst_out       <= inst;
            imm            <= d3r.imm | d2ri12.imm | d1ri20.imm;
            invtlb_op      <= d3r.invtlb_op | d2ri12.invtlb_op | d1ri20.invtlb_op;
            reg1_read_addr <= inst[9:5];    // rj
            reg2_read_addr <= inst[14:10];  // rk
            reg_write_addr <= inst[4:0];    // rd
        end
    end
endmodule

`default_nettype wire

//--- hw/la_decode_pkg.sv
`default_nettype none

package la_decode_pkg;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] si20;
            logic [4:0]  rd;
        } fmt_1ri20;
    } inst_word_t;

    // inst[31:15]
    localparam logic [16:0]
        ADDW_OPCODE    = 17'h00020, SUBW_OPCODE    = 17'h00022, SLT_OPCODE     = 17'h00024,
        SLTU_OPCODE    = 17'h00025, NOR_OPCODE     = 17'h00028, AND_OPCODE     = 17'h00029,
        OR_OPCODE      = 17'h0002a, XOR_OPCODE     = 17'h0002b, SLLW_OPCODE    = 17'h0002e,
        SRLW_OPCODE    = 17'h0002f, SRAW_OPCODE    = 17'h00030, MULW_OPCODE    = 17'h00038,
        MULHW_OPCODE   = 17'h00039, MULHWU_OPCODE  = 17'h0003a, DIVW_OPCODE    = 17'h00040,
        MODW_OPCODE    = 17'h00041, DIVWU_OPCODE   = 17'h00042, MODWU_OPCODE   = 17'h00043,
        BREAK_OPCODE   = 17'h00054, SYSCALL_OPCODE = 17'h00056, SLLIW_OPCODE   = 17'h00081,
        SRLIW_OPCODE   = 17'h00089, SRAIW_OPCODE   = 17'h00091, IDLE_OPCODE    = 17'h00c91,
        INVTLB_OPCODE  = 17'h00c93, DBAR_OPCODE    = 17'h070e4, IBAR_OPCODE    = 17'h070e5;

    // inst[31:22]
    localparam logic [9:0]
        SLTI_OPCODE  = 10'h008, SLTUI_OPCODE = 10'h009, ADDIW_OPCODE = 10'h00a,
        ANDI_OPCODE  = 10'h00d, ORI_OPCODE   = 10'h00e, XORI_OPCODE  = 10'h00f;

    // inst[31:25]
    localparam logic [6:0]
        LU12IW_OPCODE    = 7'h0a,
        PCADDU12I_OPCODE = 7'h0e;

    localparam int ALUOP_W = 8;
    localparam logic [ALUOP_W-1:0]
        ALU_NOP    = 8'd0,  ALU_ADDW    = 8'd1,  ALU_SUBW  = 8'd2,  ALU_SLT    = 8'd3,
        ALU_SLTU   = 8'd4,  ALU_NOR     = 8'd5,  ALU_AND   = 8'd6,  ALU_OR     = 8'd7,
        ALU_XOR    = 8'd8,  ALU_SLLW    = 8'd9,  ALU_SRLW  = 8'd10, ALU_SRAW   = 8'd11,
        ALU_MULW   = 8'd12, ALU_MULHW   = 8'd13, ALU_MULHWU = 8'd14, ALU_DIVW  = 8'd15,
        ALU_MODW   = 8'd16, ALU_DIVWU   = 8'd17, ALU_MODWU = 8'd18, ALU_BREAK  = 8'd19,
        ALU_SYSCALL = 8'd20, ALU_SLLIW  = 8'd21, ALU_SRLIW = 8'd22, ALU_SRAIW  = 8'd23,
        ALU_IDLE   = 8'd24, ALU_INVTLB  = 8'd25, ALU_DBAR  = 8'd26, ALU_IBAR   = 8'd27,
        ALU_ADDIW  = 8'd28, ALU_SLTI    = 8'd29, ALU_SLTUI = 8'd30, ALU_ANDI   = 8'd31,
        ALU_ORI    = 8'd32, ALU_XORI    = 8'd33, ALU_LU12IW = 8'd34, ALU_PCADDU12I = 8'd35;

    localparam int ALUSEL_W = 3;
    localparam logic [ALUSEL_W-1:0]
        ALU_SEL_NOP        = 3'd0,
        ALU_SEL_ARITHMETIC = 3'd1,
        ALU_SEL_MUL        = 3'd2,
        ALU_SEL_LUI        = 3'd3;

    localparam int ECODE_W = 7;
    localparam logic [ECODE_W-1:0]
        ECODE_NONE = 7'd0,
        ECODE_ADEF = 7'd8,   // fetch address error
        ECODE_INE  = 7'd13;  // instruction not exist

endpackage

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk
);
    localparam realtime HALF_PERIOD = 5ns;  // 10 ns clock

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;
endmodule

`default_nettype wire

//--- verif/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode;
    localparam int N_ROWS     = 44;
    localparam int RST_CYCLES = 16;
    localparam int PERIOD_NS  = 10;
    // {fetch_valid, stall, flush, odd pc}
    localparam logic [3:0] RUN = 4'b1000;
    localparam logic [3:0] STL = 4'b1100;
    localparam logic [3:0] FLS = 4'b1010;
    localparam logic [3:0] FSL = 4'b1110;
    localparam logic [3:0] OFF = 4'b0000;
    localparam logic [3:0] MIS = 4'b1001;
    localparam logic [2:0] S_NOP = la_decode_pkg::ALU_SEL_NOP;
    localparam logic [2:0] S_AR  = la_decode_pkg::ALU_SEL_ARITHMETIC;
    localparam logic [2:0] S_MUL = la_decode_pkg::ALU_SEL_MUL;
    localparam logic [2:0] S_LUI = la_decode_pkg::ALU_SEL_LUI;
    // imm kinds
    localparam int K_0   = 0;
    localparam int K_U5  = 1;
    localparam int K_S12 = 2;
    localparam int K_Z12 = 3;
    localparam int K_20  = 4;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic        stall;
    logic        flush;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        id_valid;
    logic [31:0] pc_out;
    logic [31:0] inst_out;
    logic        reg_write_en;
    logic [la_decode_pkg::ALUOP_W-1:0]  aluop;
    logic [la_decode_pkg::ALUSEL_W-1:0] alusel;
    logic [31:0] imm;
    logic        reg1_read_en;
    logic        reg2_read_en;
    logic [4:0]  reg1_read_addr;
    logic [4:0]  reg2_read_addr;
    logic [4:0]  reg_write_addr;
    logic        is_privilege;
    logic [4:0]  invtlb_op;
    logic [1:0]  is_exception;
    logic [la_decode_pkg::ECODE_W-1:0]  pc_exception_cause;
    logic [la_decode_pkg::ECODE_W-1:0]  decoder_exception_cause;

    string       names  [N_ROWS];
    logic [31:0] words  [N_ROWS];
    logic [31:0] pcs    [N_ROWS];
    logic [3:0]  ctls   [N_ROWS];
    logic [la_decode_pkg::ALUOP_W-1:0]  ops [N_ROWS];
    logic [la_decode_pkg::ALUSEL_W-1:0] sels [N_ROWS];
    logic [3:0]  flags  [N_ROWS];  // wen, r1en, r2en, priv
    int          ikinds [N_ROWS];
    int          n_rows;
    int          n_fail;
    int          n_err;
    int          test_err;
    logic [31:0] seed;

    // expected state of the id registers
    logic        e_seen;
    logic        e_valid;
    logic [31:0] e_pc;
    logic [31:0] e_inst;
    logic [la_decode_pkg::ALUOP_W-1:0]  e_op;
    logic [la_decode_pkg::ALUSEL_W-1:0] e_sel;
    logic [3:0]  e_flags;
    logic [31:0] e_imm;
    logic [4:0]  e_inv;
    logic [1:0]  e_exc;

    tb_clkgen clkgen_inst (.clk(clk));

    decode_top decode_top_inst (.*);

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] w, input int kind);
        la_decode_pkg::inst_word_t iw;
        int s12;
        iw  = w;
        s12 = int'(iw.fmt_2ri12.si12);
        if (s12 >= 2048)
            s12 -= 4096;  // negative si12
        case (kind)
            K_U5:    return 32'(iw.fmt_3r.rk);
            K_S12:   return 32'(s12);
            K_Z12:   return 32'(iw.fmt_2ri12.si12);
            K_20:    return 32'(iw.fmt_1ri20.si20) * 32'd4096;
            default: return 32'b0;
        endcase
    endfunction

    task automatic add_row(input string name, input logic [31:0] base, input logic [3:0] ctl,
                           input logic [7:0] op, input logic [2:0] sel, input logic [3:0] fl,
                           input int ik);
        logic [31:0] mask;
        mask = (ik == K_20) ? 32'h01ff_ffff :
               (ik == K_S12 || ik == K_Z12) ? 32'h003f_ffff : 32'h0000_7fff;
        seed = next_rand(seed);
        names[n_rows] = name;
        words[n_rows] = base | ((seed >> 7) & mask);
        if (ik == K_S12 || ik == K_Z12)
            words[n_rows][21] = 1'b1;  // negative si12
        pcs[n_rows]    = 32'h1c00_0000 + 32'(n_rows * 4) + (ctl[0] ? 32'd2 : 32'd0);
        ctls[n_rows]   = ctl;
        ops[n_rows]    = op;
        sels[n_rows]   = sel;
        flags[n_rows]  = fl;
        ikinds[n_rows] = ik;
        n_rows++;
    endtask

    task automatic fill_table();
        add_row("add.w",     32'h00100000, RUN, la_decode_pkg::ALU_ADDW,   S_AR,  4'b1110, K_0);
        add_row("sub.w",     32'h00110000, RUN, la_decode_pkg::ALU_SUBW,   S_AR,  4'b1110, K_0);
        add_row("slt",       32'h00120000, RUN, la_decode_pkg::ALU_SLT,    S_AR,  4'b1110, K_0);
        add_row("sltu",      32'h00128000, RUN, la_decode_pkg::ALU_SLTU,   S_AR,  4'b1110, K_0);
        add_row("nor",       32'h00140000, RUN, la_decode_pkg::ALU_NOR,    S_AR,  4'b1110, K_0);
        add_row("and",       32'h00148000, RUN, la_decode_pkg::ALU_AND,    S_AR,  4'b1110, K_0);
        add_row("or",        32'h00150000, RUN, la_decode_pkg::ALU_OR,     S_AR,  4'b1110, K_0);
        add_row("xor",       32'h00158000, RUN, la_decode_pkg::ALU_XOR,    S_AR,  4'b1110, K_0);
        add_row("sll.w",     32'h00170000, RUN, la_decode_pkg::ALU_SLLW,   S_AR,  4'b1110, K_0);
        add_row("srl.w",     32'h00178000, RUN, la_decode_pkg::ALU_SRLW,   S_AR,  4'b1110, K_0);
        add_row("sra.w",     32'h00180000, RUN, la_decode_pkg::ALU_SRAW,   S_AR,  4'b1110, K_0);
        add_row("mul.w",     32'h001c0000, RUN, la_decode_pkg::ALU_MULW,   S_MUL, 4'b1110, K_0);
        add_row("mulh.w",    32'h001c8000, RUN, la_decode_pkg::ALU_MULHW,  S_MUL, 4'b1110, K_0);
        add_row("mulh.wu",   32'h001d0000, RUN, la_decode_pkg::ALU_MULHWU, S_MUL, 4'b1110, K_0);
        add_row("div.w",     32'h00200000, RUN, la_decode_pkg::ALU_DIVW,   S_MUL, 4'b1110, K_0);
        add_row("mod.w",     32'h00208000, RUN, la_decode_pkg::ALU_MODW,   S_MUL, 4'b1110, K_0);
        add_row("div.wu",    32'h00210000, RUN, la_decode_pkg::ALU_DIVWU,  S_MUL, 4'b1110, K_0);
        add_row("mod.wu",    32'h00218000, RUN, la_decode_pkg::ALU_MODWU,  S_MUL, 4'b1110, K_0);
        add_row("slli.w",    32'h00408000, RUN, la_decode_pkg::ALU_SLLIW,  S_AR,  4'b1100, K_U5);
        add_row("srli.w",    32'h00448000, RUN, la_decode_pkg::ALU_SRLIW,  S_AR,  4'b1100, K_U5);
        add_row("srai.w",    32'h00488000, RUN, la_decode_pkg::ALU_SRAIW,  S_AR,  4'b1100, K_U5);
        add_row("break",     32'h002a0000, RUN, la_decode_pkg::ALU_BREAK,  S_NOP, 4'b0000, K_0);
        add_row("syscall",   32'h002b0000, RUN, la_decode_pkg::ALU_SYSCALL, S_NOP, 4'b0000, K_0);
        add_row("idle",      32'h06488000, RUN, la_decode_pkg::ALU_IDLE,   S_NOP, 4'b0001, K_0);
        add_row("invtlb",    32'h06498000, RUN, la_decode_pkg::ALU_INVTLB, S_NOP, 4'b0111, K_0);
        add_row("dbar",      32'h38720000, RUN, la_decode_pkg::ALU_DBAR,   S_NOP, 4'b0000, K_0);
        add_row("ibar",      32'h38728000, RUN, la_decode_pkg::ALU_IBAR,   S_NOP, 4'b0000, K_0);
        add_row("addi.w",    32'h02800000, RUN, la_decode_pkg::ALU_ADDIW,  S_AR,  4'b1100, K_S12);
        add_row("slti",      32'h02000000, RUN, la_decode_pkg::ALU_SLTI,   S_AR,  4'b1100, K_S12);
        add_row("sltui",     32'h02400000, RUN, la_decode_pkg::ALU_SLTUI,  S_AR,  4'b1100, K_S12);
        add_row("andi",      32'h03400000, RUN, la_decode_pkg::ALU_ANDI,   S_AR,  4'b1100, K_Z12);
        add_row("ori",       32'h03800000, RUN, la_decode_pkg::ALU_ORI,    S_AR,  4'b1100, K_Z12);
        add_row("xori",      32'h03c00000, RUN, la_decode_pkg::ALU_XORI,   S_AR,  4'b1100, K_Z12);
        add_row("lu12i.w",   32'h14000000, RUN, la_decode_pkg::ALU_LU12IW, S_LUI, 4'b1000, K_20);
        add_row("pcaddu12i", 32'h1c000000, RUN, la_decode_pkg::ALU_PCADDU12I, S_AR, 4'b1000, K_20);
        add_row("bad word",  32'hffff8000, RUN, la_decode_pkg::ALU_NOP,    S_NOP, 4'b0000, K_0);
        add_row("add.w odd", 32'h00100000, MIS, la_decode_pkg::ALU_ADDW,   S_AR,  4'b1110, K_0);
        add_row("bad odd",   32'hffff8000, MIS, la_decode_pkg::ALU_NOP,    S_NOP, 4'b0000, K_0);
        add_row("stall",     32'h00150000, STL, la_decode_pkg::ALU_OR,     S_AR,  4'b1110, K_0);
        add_row("flush",     32'h00148000, FLS, la_decode_pkg::ALU_AND,    S_AR,  4'b1110, K_0);
        add_row("add.w 2",   32'h00100000, RUN, la_decode_pkg::ALU_ADDW,   S_AR,  4'b1110, K_0);
        add_row("flush+stl", 32'h001c0000, FSL, la_decode_pkg::ALU_MULW,   S_MUL, 4'b1110, K_0);
        add_row("ori 2",     32'h03800000, RUN, la_decode_pkg::ALU_ORI,    S_AR,  4'b1100, K_Z12);
        add_row("no fetch",  32'h00110000, OFF, la_decode_pkg::ALU_SUBW,   S_AR,  4'b1110, K_0);
    endtask

    task automatic apply_row(input int i);
        fetch_valid <= ctls[i][3];
        stall       <= ctls[i][2];
        flush       <= ctls[i][1];
        pc          <= pcs[i];
        inst        <= words[i];
    endtask

    // what the id registers hold after the edge that saw row i
    task automatic update_model(input int i);
        if (ctls[i][1]) begin
            e_valid = 1'b0;
            e_exc   = 2'b00;
        end else if (!ctls[i][2]) begin
            e_valid = ctls[i][3];
            if (ctls[i][3]) begin
                e_seen  = 1'b1;
                e_pc    = pcs[i];
                e_inst  = words[i];
                e_op    = ops[i];
                e_sel   = sels[i];
                e_flags = flags[i];
                e_imm   = expected_imm(words[i], ikinds[i]);
                e_inv   = (ops[i] == la_decode_pkg::ALU_INVTLB) ? words[i][4:0] : 5'b0;
                e_exc   = {ops[i] == la_decode_pkg::ALU_NOP, ctls[i][0]};
            end
        end
    endtask

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s expected 0x%08h actual 0x%08h", test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic check_outputs(input string t);
        la_decode_pkg::inst_word_t iw;
        iw = e_inst;
        compare_value(t, "id_valid", 32'(e_valid), 32'(id_valid));
        compare_value(t, "is_exception", 32'(e_exc), 32'(is_exception));
        compare_value(t, "pc_cause", 32'(e_exc[0] ? la_decode_pkg::ECODE_ADEF :
                      la_decode_pkg::ECODE_NONE), 32'(pc_exception_cause));
        compare_value(t, "dec_cause", 32'(e_exc[1] ? la_decode_pkg::ECODE_INE :
                      la_decode_pkg::ECODE_NONE), 32'(decoder_exception_cause));
        compare_value(t, "aluop", 32'(e_op), 32'(aluop));
        compare_value(t, "alusel", 32'(e_sel), 32'(alusel));
        compare_value(t, "reg_write_en", 32'(e_flags[3]), 32'(reg_write_en));
        compare_value(t, "reg1_read_en", 32'(e_flags[2]), 32'(reg1_read_en));
        compare_value(t, "reg2_read_en", 32'(e_flags[1]), 32'(reg2_read_en));
        compare_value(t, "is_privilege", 32'(e_flags[0]), 32'(is_privilege));
        if (e_seen) begin  // unreset fields are known after a capture
            compare_value(t, "pc_out", e_pc, pc_out);
            compare_value(t, "inst_out", e_inst, inst_out);
            compare_value(t, "imm", e_imm, imm);
            compare_value(t, "invtlb_op", 32'(e_inv), 32'(invtlb_op));
            compare_value(t, "reg1_read_addr", 32'(iw.fmt_3r.rj), 32'(reg1_read_addr));
            compare_value(t, "reg2_read_addr", 32'(iw.fmt_3r.rk), 32'(reg2_read_addr));
            compare_value(t, "reg_write_addr", 32'(iw.fmt_3r.rd), 32'(reg_write_addr));
        end
    endtask

    task automatic report_test(input string t);
        if (test_err == 0) begin
            $display("ok     %s", t);
        end else begin
            $display("error  %s, %0d mismatches", t, test_err);
            n_fail++;
            n_err += test_err;
        end
        test_err = 0;
    endtask

    initial begin
        #((N_ROWS + RST_CYCLES + 20) * PERIOD_NS);
        $display("timeout, the test table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        pc          = 32'b0;
        inst        = 32'b0;
        seed        = 32'h85881024;
        n_rows      = 0;
        n_fail      = 0;
        n_err       = 0;
        test_err    = 0;
        e_seen      = 1'b0;
        e_valid     = 1'b0;
        e_flags     = 4'b0;
        e_op        = la_decode_pkg::ALU_NOP;
        e_sel       = la_decode_pkg::ALU_SEL_NOP;
        e_exc       = 2'b00;
        fill_table();
        if (n_rows != N_ROWS) begin
            $display("test table holds %0d rows instead of %0d", n_rows, N_ROWS);
            n_err++;
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs("reset");
        report_test("reset");
        // row i is driven on the edge that captures row i-1
        for (int i = 0; i <= N_ROWS; i++) begin
            @(posedge clk);
            if (i < N_ROWS) begin
                apply_row(i);
            end else begin
                fetch_valid <= 1'b0;
                stall       <= 1'b0;
                flush       <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                update_model(i - 1);
                check_outputs(names[i - 1]);
                report_test(names[i - 1]);
            end
        end
        $display("tests %0d, failing tests %0d, mismatches %0d", N_ROWS + 1, n_fail, n_err);
        if (n_err == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end
endmodule

`default_nettype wire

//--- verilog.f
hw/la_decode_pkg.sv
hw/decode_if.sv
hw/id_3r.sv
hw/id_2ri12.sv
hw/id_1ri20.sv
hw/id_stage.sv
hw/decode_top.sv
verif/tb_clkgen.sv
verif/tb_decode.sv
